// ==== src/router_pkg.sv ====
`default_nettype none

package router_pkg;

    ////////////////////////////////////////////////////////////
    // Port numbering

    // Ports 0 to 5 are usable, codes 6 and 7 are out of range
    localparam int NUM_PORTS = 6;
    localparam int PORT_W    = 3;

    typedef logic [PORT_W-1:0] port_t;

    ////////////////////////////////////////////////////////////
    // Header fields

    localparam int ADDR_W = 8;
    localparam int TTL_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TTL_W-1:0]  ttl_t;

    // Lowest TTL that still survives one more hop
    localparam ttl_t TTL_MIN_LIVE = ttl_t'(2);

    ////////////////////////////////////////////////////////////
    // Statistics

    localparam int COUNT_W = 16;

    typedef logic [COUNT_W-1:0] count_t;

    // Counters stick here
    localparam count_t COUNT_MAX = '1;

endpackage

`default_nettype wire

// ==== src/router_ctrl_pkg.sv ====
`default_nettype none

package router_ctrl_pkg;

    // Route table size
    localparam int TABLE_DEPTH = 8;
    localparam int TABLE_IDX_W = $clog2(TABLE_DEPTH);

    typedef logic [TABLE_IDX_W-1:0] table_idx_t;

    ////////////////////////////////////////////////////////////
    // Register write port

    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 16;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    // 0 to 7 are table entries
    localparam reg_addr_t DEFAULT_ROUTE_ADDR = reg_addr_t'(8);

    // Table entry word: valid, port, destination
    localparam int ENTRY_VALID_BIT = 15;
    localparam int ENTRY_PORT_LSB  = 8;
    localparam int ENTRY_DST_LSB   = 0;

    // Default route word: enable, port
    localparam int DEFAULT_EN_BIT   = 3;
    localparam int DEFAULT_PORT_LSB = 0;

    ////////////////////////////////////////////////////////////
    // Drop reasons

    typedef logic [1:0] drop_reason_t;

    localparam drop_reason_t DROP_NONE     = 2'd0;
    localparam drop_reason_t DROP_TTL      = 2'd1;
    localparam drop_reason_t DROP_NO_ROUTE = 2'd2;
    localparam drop_reason_t DROP_HAIRPIN  = 2'd3;

endpackage

`default_nettype wire

// ==== src/router_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Result of the destination lookup, one cycle after the header
interface lookup_if;
    import router_pkg::*;

    logic  valid;
    logic  hit;
    port_t egr_port;
    logic  from_default;

    modport tbl (
        output valid,
        output hit,
        output egr_port,
        output from_default
    );

    modport decision (
        input valid,
        input hit,
        input egr_port,
        input from_default
    );

endinterface

// Checked header fields, aligned with the lookup result
interface hdr_check_if;
    import router_pkg::*;

    logic  valid;
    logic  expired;
    ttl_t  ttl_next;
    addr_t dst;
    port_t ing_port;

    modport check (
        output valid,
        output expired,
        output ttl_next,
        output dst,
        output ing_port
    );

    modport decision (
        input valid,
        input expired,
        input ttl_next,
        input dst,
        input ing_port
    );

endinterface

`default_nettype wire

// ==== src/route_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_table (
    input  var logic                      clk,
    input  var logic                      rst,
    input  var logic                      pkt_valid,
    input  var router_pkg::addr_t         pkt_dst,
    input  var logic                      reg_wr,
    input  var router_ctrl_pkg::reg_addr_t reg_addr,
    input  var router_ctrl_pkg::reg_data_t reg_wdata,
    lookup_if.tbl                         lkp
);

    import router_pkg::*;
    import router_ctrl_pkg::*;

    // Table storage
    logic [TABLE_DEPTH-1:0] entry_valid;
    port_t                  entry_port [TABLE_DEPTH];
    addr_t                  entry_dst  [TABLE_DEPTH];
    logic                   def_en;
    port_t                  def_port;

    // Write decode
    table_idx_t wr_idx;
    port_t      wr_entry_port;
    addr_t      wr_entry_dst;
    port_t      wr_def_port;
    logic       entry_wr;
    logic       def_wr;

    // Lookup
    logic  match_hit;
    port_t match_port;

    ////////////////////////////////////////////////////////////
    // Register writes

    assign wr_idx        = reg_addr[TABLE_IDX_W-1:0];
    assign wr_entry_port = reg_wdata[ENTRY_PORT_LSB +: PORT_W];
    assign wr_entry_dst  = reg_wdata[ENTRY_DST_LSB +: ADDR_W];
    assign wr_def_port   = reg_wdata[DEFAULT_PORT_LSB +: PORT_W];

    // Out of range ports leave the target untouched
    assign entry_wr = reg_wr && (reg_addr < TABLE_DEPTH) && (wr_entry_port < NUM_PORTS);
    assign def_wr   = reg_wr && (reg_addr == DEFAULT_ROUTE_ADDR) && (wr_def_port < NUM_PORTS);

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            def_en      <= 1'b0;
        end else begin
            if (entry_wr) begin
                entry_valid[wr_idx] <= reg_wdata[ENTRY_VALID_BIT];
            end
            if (def_wr) begin
                def_en <= reg_wdata[DEFAULT_EN_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (entry_wr) begin
            entry_port[wr_idx] <= wr_entry_port;
            entry_dst[wr_idx]  <= wr_entry_dst;
        end
        if (def_wr) begin
            def_port <= wr_def_port;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lookup

    // Scan from the top so the lowest matching index is left standing
    // With no match the default port stays in place
    always_comb begin
        match_hit  = 1'b0;
        match_port = def_port;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && (entry_dst[i] == pkt_dst)) begin
                match_hit  = 1'b1;
                match_port = entry_port[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lkp.valid <= 1'b0;
        end else begin
            lkp.valid <= pkt_valid;
        end
    end

    always_ff @(posedge clk) begin
        lkp.hit          <= match_hit || def_en;
        lkp.egr_port     <= match_port;
        lkp.from_default <= !match_hit && def_en;
    end

    // A route only ever points at a real port
    a_hit_port_range: assert property (
        @(posedge clk) disable iff (rst)
        (lkp.valid && lkp.hit) |-> (lkp.egr_port < NUM_PORTS)
    ) else $error("route_table: hit on out of range port %0d", lkp.egr_port);

endmodule

`default_nettype wire

// ==== src/ttl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttl_checker (
    input  var logic              clk,
    input  var logic              rst,
    input  var logic              pkt_valid,
    input  var router_pkg::addr_t pkt_dst,
    input  var router_pkg::ttl_t  pkt_ttl,
    input  var router_pkg::port_t pkt_ing_port,
    hdr_check_if.check            chk
);

    import router_pkg::*;

    logic expired;

    // 0 and 1 cannot take another hop
    assign expired = (pkt_ttl < TTL_MIN_LIVE);

    always_ff @(posedge clk) begin
        if (rst) begin
            chk.valid <= 1'b0;
        end else begin
            chk.valid <= pkt_valid;
        end
    end

    // Header fields ride along with the check result
    always_ff @(posedge clk) begin
        chk.expired  <= expired;
        chk.ttl_next <= pkt_ttl - 1'b1;
        chk.dst      <= pkt_dst;
        chk.ing_port <= pkt_ing_port;
    end

    a_valid_delay: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> (chk.valid == $past(pkt_valid))
    ) else $error("ttl_checker: check strobe out of step with ingress");

endmodule

`default_nettype wire

// ==== src/forward_decision.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward_decision (
    input  var logic                      clk,
    input  var logic                      rst,
    lookup_if.decision                    lkp,
    hdr_check_if.decision                 chk,
    output logic                          egr_valid,
    output router_pkg::port_t             egr_port,
    output router_pkg::addr_t             egr_dst,
    output router_pkg::ttl_t              egr_ttl,
    output logic                          drop_valid,
    output router_ctrl_pkg::drop_reason_t drop_reason,
    output router_pkg::count_t            fwd_count,
    output router_pkg::count_t            drop_count
);

    import router_pkg::*;
    import router_ctrl_pkg::*;

    drop_reason_t reason;
    logic         is_fwd;
    logic         is_drop;

    ////////////////////////////////////////////////////////////
    // Verdict

    // TTL beats missing route beats hairpin
    always_comb begin
        if (chk.expired) begin
            reason = DROP_TTL;
        end else if (!lkp.hit) begin
            reason = DROP_NO_ROUTE;
        end else if (lkp.egr_port == chk.ing_port) begin
            reason = DROP_HAIRPIN;
        end else begin
            reason = DROP_NONE;
        end
    end

    assign is_fwd  = chk.valid && (reason == DROP_NONE);
    assign is_drop = chk.valid && (reason != DROP_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            egr_valid  <= 1'b0;
            drop_valid <= 1'b0;
        end else begin
            egr_valid  <= is_fwd;
            drop_valid <= is_drop;
        end
    end

    always_ff @(posedge clk) begin
        egr_port    <= lkp.egr_port;
        egr_dst     <= chk.dst;
        egr_ttl     <= chk.ttl_next;
        drop_reason <= reason;
    end

    ////////////////////////////////////////////////////////////
    // Counters

    // Count on the same edge that raises the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_count  <= '0;
            drop_count <= '0;
        end else begin
            if (is_fwd && (fwd_count != COUNT_MAX)) begin
                fwd_count <= fwd_count + 1'b1;
            end
            if (is_drop && (drop_count != COUNT_MAX)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    a_one_outcome: assert property (
        @(posedge clk) disable iff (rst)
        !(egr_valid && drop_valid)
    ) else $error("forward_decision: forward and drop in the same cycle");

    // Both front blocks must stay in lockstep
    a_front_aligned: assert property (
        @(posedge clk) disable iff (rst)
        lkp.valid == chk.valid
    ) else $error("forward_decision: lookup and check strobes misaligned");

endmodule

`default_nettype wire

// ==== src/mini_router_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_router_top (
    input  var logic                       clk,
    input  var logic                       rst,

    // Ingress header
    input  var logic                       pkt_valid,
    input  var router_pkg::addr_t          pkt_dst,
    input  var router_pkg::ttl_t           pkt_ttl,
    input  var router_pkg::port_t          pkt_ing_port,

    // Table programming
    input  var logic                       reg_wr,
    input  var router_ctrl_pkg::reg_addr_t reg_addr,
    input  var router_ctrl_pkg::reg_data_t reg_wdata,

    // Egress and drop results
    output logic                           egr_valid,
    output router_pkg::port_t              egr_port,
    output router_pkg::addr_t              egr_dst,
    output router_pkg::ttl_t               egr_ttl,
    output logic                           drop_valid,
    output router_ctrl_pkg::drop_reason_t  drop_reason,
    output router_pkg::count_t             fwd_count,
    output router_pkg::count_t             drop_count
);

    lookup_if    lkp_if ();
    hdr_check_if chk_if ();

    ////////////////////////////////////////////////////////////
    // Parallel front stage

    route_table u_route_table (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pkt_valid ( pkt_valid ),
        .pkt_dst   ( pkt_dst   ),
        .reg_wr    ( reg_wr    ),
        .reg_addr  ( reg_addr  ),
        .reg_wdata ( reg_wdata ),
        .lkp       ( lkp_if    )
    );

    ttl_checker u_ttl_checker (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .pkt_valid    ( pkt_valid    ),
        .pkt_dst      ( pkt_dst      ),
        .pkt_ttl      ( pkt_ttl      ),
        .pkt_ing_port ( pkt_ing_port ),
        .chk          ( chk_if       )
    );

    ////////////////////////////////////////////////////////////
    // Decision stage

    forward_decision u_forward_decision (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .lkp         ( lkp_if      ),
        .chk         ( chk_if      ),
        .egr_valid   ( egr_valid   ),
        .egr_port    ( egr_port    ),
        .egr_dst     ( egr_dst     ),
        .egr_ttl     ( egr_ttl     ),
        .drop_valid  ( drop_valid  ),
        .drop_reason ( drop_reason ),
        .fwd_count   ( fwd_count   ),
        .drop_count  ( drop_count  )
    );

endmodule

`default_nettype wire

// ==== verification/mini_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_router_tb;

    import router_pkg::*;
    import router_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_DIRECTED = 20;
    localparam int NUM_RANDOM   = 300;
    // Covers register writes, drain gaps and the two resets
    localparam int MARGIN_NS    = 3000;
    localparam int WATCHDOG_NS  = (NUM_DIRECTED + NUM_RANDOM) * CLK_PERIOD + MARGIN_NS;

    // Expected result of one header
    typedef struct packed {
        logic         fwd;
        logic         drop;
        port_t        port;
        addr_t        dst;
        ttl_t         ttl;
        drop_reason_t reason;
    } outcome_t;

    logic         clk;
    logic         rst;
    logic         pkt_valid;
    addr_t        pkt_dst;
    ttl_t         pkt_ttl;
    port_t        pkt_ing_port;
    logic         reg_wr;
    reg_addr_t    reg_addr;
    reg_data_t    reg_wdata;
    logic         egr_valid;
    port_t        egr_port;
    addr_t        egr_dst;
    ttl_t         egr_ttl;
    logic         drop_valid;
    drop_reason_t drop_reason;
    count_t       fwd_count;
    count_t       drop_count;

    // Shadow of the route table and the two stage delay line
    logic     sh_valid [TABLE_DEPTH];
    port_t    sh_port  [TABLE_DEPTH];
    addr_t    sh_dst   [TABLE_DEPTH];
    logic     sh_def_en;
    port_t    sh_def_port;
    outcome_t exp_d1;
    outcome_t exp_d2;
    count_t   model_fwd;
    count_t   model_drop;

    int error_count;
    int test_count;
    int tests_failed;
    int errors_at_start;

    mini_router_top UUT (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .pkt_valid    ( pkt_valid    ),
        .pkt_dst      ( pkt_dst      ),
        .pkt_ttl      ( pkt_ttl      ),
        .pkt_ing_port ( pkt_ing_port ),
        .reg_wr       ( reg_wr       ),
        .reg_addr     ( reg_addr     ),
        .reg_wdata    ( reg_wdata    ),
        .egr_valid    ( egr_valid    ),
        .egr_port     ( egr_port     ),
        .egr_dst      ( egr_dst      ),
        .egr_ttl      ( egr_ttl      ),
        .drop_valid   ( drop_valid   ),
        .drop_reason  ( drop_reason  ),
        .fwd_count    ( fwd_count    ),
        .drop_count   ( drop_count   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    // Lowest matching index, then the default route
    function automatic outcome_t predict(input logic valid, input addr_t dst,
                                         input ttl_t ttl, input port_t ing);
        outcome_t o;
        logic     hit;
        port_t    port;
        hit  = 1'b0;
        port = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (!hit && sh_valid[i] && (sh_dst[i] == dst)) begin
                hit  = 1'b1;
                port = sh_port[i];
            end
        end
        if (!hit && sh_def_en) begin
            hit  = 1'b1;
            port = sh_def_port;
        end
        o.port = port;
        o.dst  = dst;
        o.ttl  = ttl - 8'd1;
        if (ttl <= 8'd1) begin
            o.reason = DROP_TTL;
        end else if (!hit) begin
            o.reason = DROP_NO_ROUTE;
        end else if (port == ing) begin
            o.reason = DROP_HAIRPIN;
        end else begin
            o.reason = DROP_NONE;
        end
        o.fwd  = valid && (o.reason == DROP_NONE);
        o.drop = valid && (o.reason != DROP_NONE);
        return o;
    endfunction

    // Lookup reads the shadow before this edge's write lands
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                sh_valid[i] <= 1'b0;
            end
            sh_def_en  <= 1'b0;
            exp_d1     <= '0;
            exp_d2     <= '0;
            model_fwd  <= '0;
            model_drop <= '0;
        end else begin
            exp_d1 <= predict(pkt_valid, pkt_dst, pkt_ttl, pkt_ing_port);
            exp_d2 <= exp_d1;
            if (exp_d1.fwd && (model_fwd != 16'hFFFF)) begin
                model_fwd <= model_fwd + 16'd1;
            end
            if (exp_d1.drop && (model_drop != 16'hFFFF)) begin
                model_drop <= model_drop + 16'd1;
            end
            if (reg_wr && (reg_addr < 4'd8) && (reg_wdata[10:8] < NUM_PORTS)) begin
                sh_valid[reg_addr[2:0]] <= reg_wdata[15];
                sh_port[reg_addr[2:0]]  <= reg_wdata[10:8];
                sh_dst[reg_addr[2:0]]   <= reg_wdata[7:0];
            end
            if (reg_wr && (reg_addr == 4'd8) && (reg_wdata[2:0] < NUM_PORTS)) begin
                sh_def_en   <= reg_wdata[3];
                sh_def_port <= reg_wdata[2:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    a_egr_strobe: assert property (
        @(posedge clk) disable iff (rst)
        egr_valid == exp_d2.fwd
    ) else report_fail($sformatf("egr_valid is %0b, expected %0b",
                                 $sampled(egr_valid), $sampled(exp_d2.fwd)));

    a_drop_strobe: assert property (
        @(posedge clk) disable iff (rst)
        drop_valid == exp_d2.drop
    ) else report_fail($sformatf("drop_valid is %0b, expected %0b",
                                 $sampled(drop_valid), $sampled(exp_d2.drop)));

    a_fwd_fields: assert property (
        @(posedge clk) disable iff (rst)
        exp_d2.fwd |->
            (egr_port == exp_d2.port) && (egr_dst == exp_d2.dst) && (egr_ttl == exp_d2.ttl)
    ) else report_fail($sformatf("forward port %0d dst %02h ttl %0d, expected %0d %02h %0d",
                                 $sampled(egr_port), $sampled(egr_dst), $sampled(egr_ttl),
                                 $sampled(exp_d2.port), $sampled(exp_d2.dst),
                                 $sampled(exp_d2.ttl)));

    a_drop_code: assert property (
        @(posedge clk) disable iff (rst)
        exp_d2.drop |-> (drop_reason == exp_d2.reason)
    ) else report_fail($sformatf("drop reason %0d, expected %0d",
                                 $sampled(drop_reason), $sampled(exp_d2.reason)));

    a_counters: assert property (
        @(posedge clk) disable iff (rst)
        (fwd_count == model_fwd) && (drop_count == model_drop)
    ) else report_fail($sformatf("counters fwd %0d drop %0d, expected %0d %0d",
                                 $sampled(fwd_count), $sampled(drop_count),
                                 $sampled(model_fwd), $sampled(model_drop)));

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic reg_data_t entry_word(input logic valid, input logic [2:0] port,
                                             input addr_t dst);
        return {valid, 4'b0000, port, dst};
    endfunction

    function automatic reg_data_t default_word(input logic en, input logic [2:0] port);
        return {12'h000, en, port};
    endfunction

    task automatic drive_cycle(input logic wr, input reg_addr_t addr, input reg_data_t data,
                               input logic valid, input addr_t dst, input ttl_t ttl,
                               input port_t ing);
        @(posedge clk);
        reg_wr       <= wr;
        reg_addr     <= addr;
        reg_wdata    <= data;
        pkt_valid    <= valid;
        pkt_dst      <= dst;
        pkt_ttl      <= ttl;
        pkt_ing_port <= ing;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        drive_cycle(1'b1, addr, data, 1'b0, '0, '0, '0);
    endtask

    task automatic send_hdr(input addr_t dst, input ttl_t ttl, input port_t ing);
        drive_cycle(1'b0, '0, '0, 1'b1, dst, ttl, ing);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);
    endtask

    task automatic apply_reset();
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic check_after_reset();
        @(posedge clk);
        assert (!egr_valid && !drop_valid && (fwd_count == 0) && (drop_count == 0))
            else report_fail("outputs or counters not cleared by reset");
    endtask

    task automatic end_test(input string name);
        idle(4);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // Back to back headers, with a table write in about one cycle of eight
    task automatic run_random();
        logic      wr;
        reg_addr_t addr;
        reg_data_t data;
        addr_t     dst;
        ttl_t      ttl;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            wr   = ($urandom_range(7, 0) == 0);
            addr = reg_addr_t'($urandom_range(15, 0));
            if (addr == 4'd8) begin
                data = default_word(1'($urandom_range(1, 0)), 3'($urandom_range(7, 0)));
            end else begin
                data = entry_word($urandom_range(3, 0) != 0, 3'($urandom_range(7, 0)),
                                  8'h20 + 8'($urandom_range(7, 0)));
            end
            dst = 8'h20 + 8'($urandom_range(9, 0));
            if ($urandom_range(3, 0) == 0) begin
                ttl = 8'($urandom_range(2, 0));
            end else begin
                ttl = 8'($urandom_range(255, 0));
            end
            drive_cycle(wr, addr, data, 1'b1, dst, ttl, 3'($urandom_range(5, 0)));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        void'($urandom(32));
        rst             = 1'b1;
        pkt_valid       = 1'b0;
        pkt_dst         = '0;
        pkt_ttl         = '0;
        pkt_ing_port    = '0;
        reg_wr          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        error_count     = 0;
        test_count      = 0;
        tests_failed    = 0;
        errors_at_start = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        check_after_reset();

        write_reg(4'd0, entry_word(1'b1, 3'd2, 8'h10));
        write_reg(4'd1, entry_word(1'b1, 3'd4, 8'h11));
        send_hdr(8'h10, 8'd64, 3'd0);
        send_hdr(8'h11, 8'd2, 3'd1);
        send_hdr(8'h10, 8'd255, 3'd5);
        end_test("match_forward");

        send_hdr(8'h77, 8'd10, 3'd0);
        write_reg(DEFAULT_ROUTE_ADDR, default_word(1'b1, 3'd3));
        send_hdr(8'h77, 8'd10, 3'd0);
        send_hdr(8'h10, 8'd10, 3'd0);
        write_reg(DEFAULT_ROUTE_ADDR, default_word(1'b0, 3'd3));
        send_hdr(8'h77, 8'd10, 3'd0);
        end_test("default_route");

        // Expired beats a missing route
        send_hdr(8'h10, 8'd0, 3'd0);
        send_hdr(8'h10, 8'd1, 3'd0);
        send_hdr(8'h77, 8'd0, 3'd1);
        end_test("ttl_expiry");

        send_hdr(8'h10, 8'd20, 3'd2);
        write_reg(4'd5, entry_word(1'b1, 3'd5, 8'h20));
        write_reg(4'd3, entry_word(1'b1, 3'd1, 8'h20));
        send_hdr(8'h20, 8'd20, 3'd0);
        write_reg(4'd3, entry_word(1'b1, 3'd6, 8'h20));
        write_reg(4'd1, entry_word(1'b1, 3'd7, 8'h20));
        write_reg(4'd12, entry_word(1'b1, 3'd0, 8'h20));
        send_hdr(8'h20, 8'd20, 3'd0);
        // Lookup alongside a write still sees entry 3
        drive_cycle(1'b1, 4'd3, entry_word(1'b0, 3'd1, 8'h20), 1'b1, 8'h20, 8'd20, 3'd0);
        send_hdr(8'h20, 8'd20, 3'd0);
        send_hdr(8'h20, 8'd20, 3'd5);
        end_test("hairpin_and_priority");

        run_random();
        end_test("random_traffic");

        @(posedge clk);
        assert ((fwd_count == model_fwd) && (drop_count == model_drop))
            else report_fail($sformatf("final counts fwd %0d drop %0d, expected %0d %0d",
                                       fwd_count, drop_count, model_fwd, model_drop));
        send_hdr(8'h20, 8'd30, 3'd0);
        apply_reset();
        check_after_reset();
        end_test("counters_and_reset");

        $display("Summary: %0d tests run, %0d tests failed, %0d check errors",
                 test_count, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/router_pkg.sv
src/router_ctrl_pkg.sv
src/router_ifs.sv
src/route_table.sv
src/ttl_checker.sv
src/forward_decision.sv
src/mini_router_top.sv
verification/mini_router_tb.sv

// ==== Bender.yml ====
package:
  name: mini_router

sources:
  # Packages first, then interfaces and RTL
  - src/router_pkg.sv
  - src/router_ctrl_pkg.sv
  - src/router_ifs.sv
  - src/route_table.sv
  - src/ttl_checker.sv
  - src/forward_decision.sv
  - src/mini_router_top.sv

  # Testbench
  - target: test
    files:
      - verification/mini_router_tb.sv
